// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep '\.sv$$' $(FLIST)) testbench/fetch_ref.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
+incdir+testbench
hdl/rv_fetch_pkg.sv
hdl/inst_rom.sv
hdl/reg_file.sv
hdl/branch_resolver.sv
hdl/fetch_ctrl.sv
hdl/fetch_top.sv
testbench/tb_fetch_top.sv

// File: hdl/branch_resolver.sv
// early decode of jal, jalr and conditional branches with taken decision and target
`timescale 1ns/100ps

module branch_resolver
  import rv_fetch_pkg::*;
(
  input  xlen_t    pc,
  input  inst_t    inst,

  // operand fetch from the register file
  output reg_idx_t rs1,
  input  xlen_t    rs1_data,
  output reg_idx_t rs2,
  input  xlen_t    rs2_data,

  output logic     jump,
  output xlen_t    jump_target
);

  logic [4:0] opcode;
  logic [2:0] funct3;
  logic       br_taken;
  xlen_t      jal_tgt;
  xlen_t      jalr_tgt;
  xlen_t      br_tgt;

  assign opcode = inst[6:2];
  assign funct3 = inst[14:12];

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  assign jal_tgt  = pc + imm_j(inst);
  assign br_tgt   = pc + imm_b(inst);
  // jalr drops bit 0 of the sum
  assign jalr_tgt = (rs1_data + imm_i(inst)) & ~xlen_t'(1);

  // only the condition selected by funct3 counts, the two reserved
  // encodings never branch
  always_comb begin
    case (funct3)
      f3_beq:  br_taken = (rs1_data == rs2_data);
      f3_bne:  br_taken = (rs1_data != rs2_data);
      f3_blt:  br_taken = ($signed(rs1_data) < $signed(rs2_data));
      f3_bge:  br_taken = ($signed(rs1_data) >= $signed(rs2_data));
      f3_bltu: br_taken = (rs1_data < rs2_data);
      f3_bgeu: br_taken = (rs1_data >= rs2_data);
      default: br_taken = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      op_jal: begin
        jump        = 1'b1;
        jump_target = jal_tgt;
      end
      op_jalr: begin
        jump        = 1'b1;
        jump_target = jalr_tgt;
      end
      op_branch: begin
        jump        = br_taken;
        jump_target = br_tgt;
      end
      default: begin
        jump        = 1'b0;
        jump_target = pc + xlen_t'(4);
      end
    endcase
  end

endmodule

// File: hdl/fetch_ctrl.sv
// fetch sequencer with fetch and decode pcs, decode valid, stall hold, redirect and squash
`timescale 1ns/100ps

module fetch_ctrl
  import rv_fetch_pkg::*;
#(
  parameter int unsigned imem_aw  = 8,
  parameter xlen_t       reset_pc = '0
) (
  input  logic               clk,
  input  logic               rst,

  input  logic               run,
  input  logic               stall,

  output logic               imem_en,
  output logic [imem_aw-1:0] imem_addr,

  output logic               dec_valid,
  output xlen_t              dec_pc,

  input  logic               jump,
  input  xlen_t              jump_target,
  output logic               redirect,
  output xlen_t              redirect_pc
);

  xlen_t fetch_pc;
  logic  dec_full;

  // one word address per cycle while running and not held
  assign imem_en   = run && !stall;
  assign imem_addr = fetch_pc[imem_aw+1:2];

  // a stalled slot is hidden but kept, so it shows once when stall falls
  assign dec_valid = dec_full && !stall;

  assign redirect    = dec_valid && jump;
  assign redirect_pc = jump_target;

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_pc <= reset_pc;
      dec_pc   <= reset_pc;
      dec_full <= 1'b0;
    end else if (!stall) begin
      // the word issued alongside a redirect is on the wrong path
      dec_full <= imem_en && !redirect;
      if (imem_en) begin
        dec_pc <= fetch_pc;
      end
      if (redirect) begin
        fetch_pc <= jump_target;
      end else if (imem_en) begin
        fetch_pc <= fetch_pc + xlen_t'(4);
      end
    end
  end

endmodule

// File: hdl/fetch_top.sv
// fetch front end top level joining sequencer, instruction memory, register file and resolver
`timescale 1ns/100ps

module fetch_top
  import rv_fetch_pkg::*;
#(
  parameter int unsigned imem_aw  = 8,
  parameter xlen_t       reset_pc = '0
) (
  input  logic               clk,
  input  logic               rst,

  input  logic               run,
  input  logic               stall,

  output logic               fetch_valid,
  output xlen_t              fetch_pc,
  output inst_t              fetch_inst,

  output logic               redirect,
  output xlen_t              redirect_pc,

  input  logic               rf_we,
  input  reg_idx_t           rf_waddr,
  input  xlen_t              rf_wdata,

  input  logic               imem_we,
  input  logic [imem_aw-1:0] imem_waddr,
  input  inst_t              imem_wdata
);

  logic               imem_en;
  logic [imem_aw-1:0] imem_addr;
  reg_idx_t           rs1;
  reg_idx_t           rs2;
  xlen_t              rs1_data;
  xlen_t              rs2_data;
  logic               jump;
  xlen_t              jump_target;

  fetch_ctrl #(
    .imem_aw     (imem_aw),
    .reset_pc    (reset_pc)
  ) u_fetch_ctrl (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .stall       (stall),
    .imem_en     (imem_en),
    .imem_addr   (imem_addr),
    .dec_valid   (fetch_valid),
    .dec_pc      (fetch_pc),
    .jump        (jump),
    .jump_target (jump_target),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  inst_rom #(
    .imem_aw (imem_aw)
  ) u_inst_rom (
    .clk     (clk),
    .en      (imem_en),
    .raddr   (imem_addr),
    .rdata   (fetch_inst),
    .we      (imem_we),
    .waddr   (imem_waddr),
    .wdata   (imem_wdata)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rs1      (rs1),
    .rs1_data (rs1_data),
    .rs2      (rs2),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata)
  );

  branch_resolver u_branch_resolver (
    .pc          (fetch_pc),
    .inst        (fetch_inst),
    .rs1         (rs1),
    .rs1_data    (rs1_data),
    .rs2         (rs2),
    .rs2_data    (rs2_data),
    .jump        (jump),
    .jump_target (jump_target)
  );

endmodule

// File: hdl/inst_rom.sv
// instruction memory with registered read, read enable hold and a load port
`timescale 1ns/100ps

module inst_rom
  import rv_fetch_pkg::*;
#(
  parameter int unsigned imem_aw = 8
) (
  input  logic               clk,

  input  logic               en,
  input  logic [imem_aw-1:0] raddr,
  output inst_t              rdata,

  input  logic               we,
  input  logic [imem_aw-1:0] waddr,
  input  inst_t              wdata
);

  localparam int unsigned depth = 2 ** imem_aw;

  inst_t mem [depth];

  // program loading, only used while fetch is stopped
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // the output register keeps its word while en is low so a stalled
  // decode stage sees the same instruction again
  always_ff @(posedge clk) begin
    if (en) begin
      rdata <= mem[raddr];
    end
  end

endmodule

// File: hdl/reg_file.sv
// integer register file, two combinational read ports and one write port, x0 reads zero
`timescale 1ns/100ps

module reg_file
  import rv_fetch_pkg::*;
(
  input  logic     clk,

  input  reg_idx_t rs1,
  output xlen_t    rs1_data,
  input  reg_idx_t rs2,
  output xlen_t    rs2_data,

  input  logic     we,
  input  reg_idx_t waddr,
  input  xlen_t    wdata
);

  // x0 has no storage
  xlen_t regs [1:31];

  always_ff @(posedge clk) begin
    if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // no bypass of a write in the same cycle, the new value shows after the edge
  always_comb begin
    if (rs1 == 5'd0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1];
    end
  end

  always_comb begin
    if (rs2 == 5'd0) begin
      rs2_data = '0;
    end else begin
      rs2_data = regs[rs2];
    end
  end

endmodule

// File: hdl/rv_fetch_pkg.sv
// shared widths, types, opcode and funct3 constants, and immediate extraction functions
package rv_fetch_pkg;

  localparam int xlen = 64;

  typedef logic [xlen-1:0] xlen_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_idx_t;

  // opcodes are compared on bits 6 to 2, the low two bits are always 2'b11
  localparam logic [4:0] op_jal    = 5'b11011;
  localparam logic [4:0] op_jalr   = 5'b11001;
  localparam logic [4:0] op_branch = 5'b11000;

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  function automatic xlen_t imm_i(input inst_t inst);
    return {{(xlen-12){inst[31]}}, inst[31:20]};
  endfunction

  // J format scatters the offset bits, bit 0 is implied zero
  function automatic xlen_t imm_j(input inst_t inst);
    return {{(xlen-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  endfunction

  function automatic xlen_t imm_b(input inst_t inst);
    return {{(xlen-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  endfunction

endpackage

// File: testbench/fetch_ref.svh
// reference immediates, branch conditions, next pc and instruction encoders
`ifndef FETCH_REF_SVH
`define FETCH_REF_SVH

function automatic logic [63:0] ref_next_pc(input logic [31:0] w, input logic [63:0] pc,
                                            input logic [63:0] a, input logic [63:0] b);
  logic [63:0] imm_i;
  logic [63:0] imm_j;
  logic [63:0] imm_b;
  logic        taken;
  imm_i = {{52{w[31]}}, w[31:20]};
  imm_j = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  imm_b = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  case (w[14:12])
    3'd0: taken = (a == b);
    3'd1: taken = (a != b);
    3'd4: taken = ($signed(a) < $signed(b));
    3'd5: taken = ($signed(a) >= $signed(b));
    3'd6: taken = (a < b);
    3'd7: taken = (a >= b);
    default: taken = 1'b0;
  endcase
  case (w[6:0])
    7'b1101111: return pc + imm_j;
    7'b1100111: return (a + imm_i) & ~64'd1;
    7'b1100011: return taken ? pc + imm_b : pc + 64'd4;
    default: return pc + 64'd4;
  endcase
endfunction

function automatic logic [31:0] enc_jal(input int off);
  logic [20:0] o;
  o = off[20:0];
  return {o[20], o[10:1], o[11], o[19:12], 5'd1, 7'b1101111};
endfunction

function automatic logic [31:0] enc_jalr(input logic [4:0] rs1, input int imm);
  logic [11:0] o;
  o = imm[11:0];
  return {o, rs1, 3'b000, 5'd1, 7'b1100111};
endfunction

function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input int off);
  logic [12:0] o;
  o = off[12:0];
  return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'b1100011};
endfunction

`endif

// File: testbench/tb_fetch_top.sv
// testbench for the fetch front end with program loading, stream checker and check task
`timescale 1ns/100ps

module tb_fetch_top;

  localparam int unsigned aw     = 8;
  localparam logic [63:0] rst_pc = 64'h0;
  localparam int          limit  = 5000;

  logic clk, rst, run, stall, rf_we, imem_we;
  logic [4:0] rf_waddr;
  logic [63:0] rf_wdata;
  logic [aw-1:0] imem_waddr;
  logic [31:0] imem_wdata;
  logic fetch_valid, redirect;
  logic [63:0] fetch_pc, redirect_pc;
  logic [31:0] fetch_inst;

  logic [63:0] reg_copy [32];
  logic [31:0] prog [256];
  integer      seed = 57439;
  logic [63:0] exp_pc;
  int          valid_count;
  logic        stall_en;

  `include "fetch_ref.svh"

  fetch_top #(.imem_aw(aw), .reset_pc(rst_pc)) dut (
    .clk(clk), .rst(rst), .run(run), .stall(stall),
    .fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_inst(fetch_inst),
    .redirect(redirect), .redirect_pc(redirect_pc),
    .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
    .imem_we(imem_we), .imem_waddr(imem_waddr), .imem_wdata(imem_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out while waiting for %s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped on timeout");
  endtask

  task automatic write_reg(input int idx, input logic [63:0] val);
    reg_copy[idx] = val;
    @(negedge clk);
    rf_we = 1'b1;
    rf_waddr = idx[4:0];
    rf_wdata = val;
    @(negedge clk);
    rf_we = 1'b0;
  endtask

  task automatic build_program();
    logic [31:0] r;
    int pa [6] = '{7, 9, 10, 0, 13, 11};
    int pb [6] = '{8, 10, 9, 9, 14, 0};
    logic [2:0] f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    int w;
    for (int i = 0; i < 256; i++) begin
      r = $random(seed);
      prog[i] = {r[31:7], 7'b0010011};
    end
    prog[8]  = enc_jal(16);
    prog[12] = enc_jal(40);
    prog[22] = enc_jal(-24);
    // x5 plus 5 and x6 minus 3 both give odd sums
    prog[16] = enc_jalr(5'd5, 5);
    prog[26] = enc_jalr(5'd6, -3);
    w = 64;
    for (int t = 0; t < 6; t++) begin
      for (int p = 0; p < 6; p++) begin
        prog[w] = enc_branch(f3[t], pa[p][4:0], pb[p][4:0], 8);
        w += 2;
      end
    end
    // spins until x12 is rewritten, then an undefined funct3 and a final self jump
    prog[140] = enc_branch(3'd0, 5'd12, 5'd0, 0);
    prog[141] = enc_branch(3'd2, 5'd1, 5'd2, 8);
    prog[143] = enc_jal(0);
  endtask

  task automatic load_program();
    for (int i = 0; i < 256; i++) begin
      @(negedge clk);
      imem_we = 1'b1;
      imem_waddr = i[aw-1:0];
      imem_wdata = prog[i];
    end
    @(negedge clk);
    imem_we = 1'b0;
  endtask

  task automatic wait_for_pc(input logic [63:0] target, input string what);
    int n;
    n = 0;
    while (exp_pc != target) begin
      @(negedge clk);
      n++;
      if (n > limit) report_timeout(what);
    end
  endtask

  task automatic wait_for_count(input int target);
    int n;
    n = 0;
    while (valid_count < target) begin
      @(negedge clk);
      n++;
      if (n > limit) report_timeout("valid fetches");
    end
  endtask

  task automatic wait_quiet();
    int n;
    int low;
    n = 0;
    low = 0;
    while (low < 3) begin
      @(negedge clk);
      low = fetch_valid ? 0 : low + 1;
      n++;
      if (n > limit) report_timeout("fetch_valid to fall after run dropped");
    end
  endtask

  // random stall pulses on the falling edge
  initial begin
    logic [31:0] r;
    forever begin
      @(negedge clk);
      if (stall_en) begin
        r = $random(seed);
        stall = (r[1:0] == 2'd0);
      end else begin
        stall = 1'b0;
      end
    end
  end

  // stream checker samples at the rising edge before registers update
  initial begin
    logic prev_valid, prev_redirect, prev_run, track;
    int gap;
    logic [31:0] w;
    logic [63:0] nxt;
    prev_valid = 1'b0;
    prev_redirect = 1'b0;
    prev_run = 1'b0;
    track = 1'b0;
    gap = 0;
    forever begin
      @(posedge clk);
      if (rst) begin
        exp_pc = rst_pc;
        track = 1'b0;
        prev_valid = 1'b0;
      end else begin
        if (fetch_valid) begin
          // a valid slot needs an address issued while run was high
          if (!prev_run) check_eq("fetch_valid", 64'(fetch_valid), 64'd0);
          w = prog[exp_pc[aw+1:2]];
          check_eq("fetch_pc", fetch_pc, exp_pc);
          check_eq("fetch_inst", 64'(fetch_inst), 64'(w));
          if (track) check_eq("invalid cycles after redirect", 64'(gap), 64'd1);
          track = 1'b0;
          nxt = ref_next_pc(w, exp_pc, reg_copy[w[19:15]], reg_copy[w[24:20]]);
          if (nxt != exp_pc + 64'd4) begin
            check_eq("redirect", 64'(redirect), 64'd1);
            check_eq("redirect_pc", redirect_pc, nxt);
            track = 1'b1;
            gap = 0;
          end else begin
            check_eq("redirect", 64'(redirect), 64'd0);
          end
          exp_pc = nxt;
          valid_count++;
        end else begin
          check_eq("redirect", 64'(redirect), 64'd0);
          // a sequential fetch must follow without a bubble
          if (prev_valid && !prev_redirect && prev_run && !stall)
            check_eq("fetch_valid", 64'(fetch_valid), 64'd1);
          if (track && !stall) gap++;
        end
        if (!run) track = 1'b0;
        prev_valid = fetch_valid;
        prev_redirect = redirect;
        prev_run = run;
      end
    end
  end

  initial begin
    rst = 1'b1;
    run = 1'b0;
    stall = 1'b0;
    stall_en = 1'b0;
    rf_we = 1'b0;
    rf_waddr = '0;
    rf_wdata = '0;
    imem_we = 1'b0;
    imem_waddr = '0;
    imem_wdata = '0;
    valid_count = 0;
    exp_pc = rst_pc;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    check_eq("fetch_pc", fetch_pc, rst_pc);
    check_eq("fetch_valid", 64'(fetch_valid), 64'd0);
    reg_copy[0] = '0;
    for (int i = 1; i < 32; i++) reg_copy[i] = {$random(seed), $random(seed)};
    reg_copy[5] = 64'd100;
    reg_copy[6] = 64'd260;
    reg_copy[8] = reg_copy[7];
    reg_copy[9][63] = 1'b1;
    reg_copy[10][63] = 1'b0;
    reg_copy[12] = '0;
    for (int i = 1; i < 32; i++) write_reg(i, reg_copy[i]);
    build_program();
    load_program();
    @(negedge clk);
    run = 1'b1;
    wait_for_count(8);
    stall_en = 1'b1;
    wait_for_pc(64'd560, "the branch loop at word 140");
    stall_en = 1'b0;
    @(negedge clk);
    run = 1'b0;
    wait_quiet();
    write_reg(12, 64'd5);
    @(negedge clk);
    run = 1'b1;
    wait_for_pc(64'd572, "the final jump at word 143");
    wait_for_count(valid_count + 4);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
